// ==== build.f ====
+incdir+logic
logic/kv_pkg.sv
logic/kv_req_queue.sv
logic/kv_mig_issue.sv
logic/kv_bucket_lookup.sv
logic/kv_store_top.sv
testbench/tb_clock_gen.sv
testbench/kv_mig_model.sv
testbench/kv_store_checker.sv
testbench/kv_store_tb.sv

// ==== logic/kv_bucket_lookup.sv ====
`default_nettype none

`include "kv_cfg.svh"

module kv_bucket_lookup
	import kv_pkg::*;
(
	input  wire          ui_mig_clk,
	input  wire          ui_mig_rst,
	input  wire          read_issued,
	input  wire kv_key_t issued_key,
	input  wire          app_rd_data_valid,
	input  wire line_t   app_rd_data,
	output logic         resp_valid,
	output logic         resp_hit
);

	kv_key_t head_key;
	logic pend_empty;
	logic take_line;
	logic s1_valid;
	line_t s1_line;
	kv_key_t s1_key;
	logic [`KV_SLOTS-1:0] s1_match;
	logic [`KV_SLOTS-1:0] s2_match;

	// keys of reads in flight, in command order
	kv_req_queue #(
		.entry_t (kv_key_t),
		.DEPTH   (`KV_QUEUE_DEPTH)
	) u_pending_keys (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (read_issued),
		.push_data  (issued_key),
		.pop        (take_line),
		.pop_data   (head_key),
		.empty      (pend_empty)
	);

	assign take_line = app_rd_data_valid && !pend_empty;

	// --------------------
	// slot compare
	// --------------------
	always_comb begin
		slot_t slot;
		for (int i = 0; i < `KV_SLOTS; i++) begin
			slot = slot_t'(s1_line[i*128 +: 128]);
			s1_match[i] = (slot.key == s1_key);
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		s1_line <= app_rd_data;
		s1_key <= head_key;
		s2_match <= s1_match;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			s1_valid <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			s1_valid <= take_line;
			resp_valid <= s1_valid;
		end
	end

	// any slot holding the key is a hit
	assign resp_hit = |s2_match;

endmodule

`default_nettype wire

// ==== logic/kv_cfg.svh ====
`ifndef KV_CFG_SVH
`define KV_CFG_SVH

// --------------------
// request queues
// --------------------

// entries per queue, also the source credit count per op
`define KV_QUEUE_DEPTH 8

// --------------------
// bucket table
// --------------------

// log2 of the bucket count
`define KV_BUCKET_BITS 4
`define KV_SLOTS 4

// set writes slot 0 only, a mask bit of 1 keeps the byte
`define KV_SET_MASK 64'hffff_ffff_ffff_0000

`endif

// ==== logic/kv_mig_issue.sv ====
`default_nettype none

`include "kv_cfg.svh"

module kv_mig_issue
	import kv_pkg::*;
(
	input  wire          ui_mig_clk,
	input  wire          ui_mig_rst,
	input  wire          init_calib_complete,
	input  wire          req_valid,
	input  wire kv_req_t req,
	input  wire          app_rdy,
	input  wire          app_wdf_rdy,
	output logic         app_en,
	output mig_req_t     app_req,
	output logic         app_wdf_wren,
	output mig_wdf_t     app_wdf,
	output logic         set_credit,
	output logic         init_mem,
	output logic         read_issued,
	output kv_key_t      issued_key
);

	issue_state_e state;
	bucket_t fill_cnt;
	logic req_valid_q;
	kv_req_t req_q;
	kv_req_t set_head;
	kv_req_t get_head;
	logic set_empty;
	logic get_empty;
	logic rr_set;
	logic fill_go;
	logic set_ok;
	logic get_ok;
	logic issue_set;
	logic issue_get;
	logic show_get;

	function automatic mig_addr_t bucket_addr(input bucket_t b);
		return mig_addr_t'({b, 6'b0});
	endfunction

	// --------------------
	// request queues
	// --------------------
	always_ff @(posedge ui_mig_clk) begin
		req_q <= req;
	end

	kv_req_queue #(
		.entry_t (kv_req_t),
		.DEPTH   (`KV_QUEUE_DEPTH)
	) u_set_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (req_valid_q && req_q.op == kv_set),
		.push_data  (req_q),
		.pop        (issue_set),
		.pop_data   (set_head),
		.empty      (set_empty)
	);

	kv_req_queue #(
		.entry_t (kv_req_t),
		.DEPTH   (`KV_QUEUE_DEPTH)
	) u_get_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (req_valid_q && req_q.op == kv_get),
		.push_data  (req_q),
		.pop        (issue_get),
		.pop_data   (get_head),
		.empty      (get_empty)
	);

	// --------------------
	// arbitration
	// --------------------
	assign fill_go = (state == st_fill) && app_rdy && app_wdf_rdy;
	assign set_ok = (state == st_run) && !set_empty && app_rdy && app_wdf_rdy;
	assign get_ok = (state == st_run) && !get_empty && app_rdy;
	assign issue_set = set_ok && (rr_set || !get_ok);
	assign issue_get = get_ok && !issue_set;
	// stays on the preferred head while the memory stalls
	assign show_get = issue_get || (!issue_set && !get_empty && (set_empty || !rr_set));

	assign app_en = fill_go || issue_set || issue_get;
	assign app_wdf_wren = fill_go || issue_set;
	assign read_issued = issue_get;
	assign issued_key = get_head.key;

	always_comb begin
		// sweep default: zero line, nothing masked
		app_req.cmd = mig_write;
		app_req.addr = bucket_addr(fill_cnt);
		app_wdf.data = '0;
		app_wdf.mask = '0;
		if (state == st_run) begin
			if (show_get) begin
				app_req.cmd = mig_read;
				app_req.addr = bucket_addr(bucket_t'(get_head.hash));
			end else begin
				app_req.addr = bucket_addr(bucket_t'(set_head.hash));
				app_wdf.data = line_t'(slot_t'{key: set_head.key, value: set_head.value});
				app_wdf.mask = `KV_SET_MASK;
			end
		end
	end

	// --------------------
	// sweep and control
	// --------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			state <= st_wait_calib;
			fill_cnt <= '0;
			init_mem <= 1'b0;
			rr_set <= 1'b0;
			set_credit <= 1'b0;
			req_valid_q <= 1'b0;
		end else begin
			req_valid_q <= req_valid;
			set_credit <= issue_set;
			if (set_ok && get_ok) begin
				rr_set <= !rr_set;
			end
			case (state)
				st_wait_calib: begin
					if (init_calib_complete) begin
						state <= st_fill;
					end
				end
				st_fill: begin
					if (fill_go) begin
						fill_cnt <= fill_cnt + 1'b1;
						// last bucket written
						if (&fill_cnt) begin
							state <= st_run;
							init_mem <= 1'b1;
						end
					end
				end
				default: begin
					state <= st_run;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/kv_pkg.sv ====
`default_nettype none

`include "kv_cfg.svh"

package kv_pkg;

	// request fields
	typedef logic [95:0] kv_key_t;
	typedef logic [31:0] kv_value_t;
	typedef logic [31:0] kv_hash_t;

	// low hash bits pick the bucket
	typedef logic [`KV_BUCKET_BITS-1:0] bucket_t;

	// memory user interface
	typedef logic [29:0] mig_addr_t;
	typedef logic [511:0] line_t;
	typedef logic [63:0] strb_t;

	typedef enum logic {
		kv_get,
		kv_set
	} kv_op_e;

	typedef struct packed {
		kv_op_e    op;
		kv_hash_t  hash;
		kv_key_t   key;
		kv_value_t value;
	} kv_req_t;

	// one of four slots in a line, key on top
	typedef struct packed {
		kv_key_t   key;
		kv_value_t value;
	} slot_t;

	typedef enum logic [2:0] {
		mig_write = 3'd0,
		mig_read  = 3'd1
	} mig_cmd_e;

	typedef struct packed {
		mig_addr_t addr;
		mig_cmd_e  cmd;
	} mig_req_t;

	typedef struct packed {
		line_t data;
		strb_t mask;
	} mig_wdf_t;

	typedef enum logic [1:0] {
		st_wait_calib,
		st_fill,
		st_run
	} issue_state_e;

endpackage

`default_nettype wire

// ==== logic/kv_req_queue.sv ====
`default_nettype none

module kv_req_queue #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 8
) (
	input  wire    ui_mig_clk,
	input  wire    ui_mig_rst,
	input  wire    push,
	input  entry_t push_data,
	input  wire    pop,
	output entry_t pop_data,
	output logic   empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign do_pop = pop && !empty;
	// a full queue still takes a push when it pops in the same cycle
	assign do_push = push && ((count != CNT_W'(DEPTH)) || do_pop);

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// head entry, shown without a register
	assign pop_data = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/kv_store_top.sv ====
`default_nettype none

module kv_store_top
	import kv_pkg::*;
(
	input  wire          ui_mig_clk,
	input  wire          ui_mig_rst,
	input  wire          init_calib_complete,
	// network side
	input  wire          req_valid,
	input  wire kv_req_t req,
	output logic         set_credit,
	output logic         init_mem,
	output logic         resp_valid,
	output logic         resp_hit,
	// memory user interface
	output logic         app_en,
	output mig_req_t     app_req,
	input  wire          app_rdy,
	output logic         app_wdf_wren,
	output mig_wdf_t     app_wdf,
	input  wire          app_wdf_rdy,
	input  wire          app_rd_data_valid,
	input  wire line_t   app_rd_data
);

	// one accepted read, with its key
	logic read_issued;
	kv_key_t issued_key;

	kv_mig_issue u_kv_mig_issue (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.init_calib_complete (init_calib_complete),
		.req_valid           (req_valid),
		.req                 (req),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.app_en              (app_en),
		.app_req             (app_req),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf             (app_wdf),
		.set_credit          (set_credit),
		.init_mem            (init_mem),
		.read_issued         (read_issued),
		.issued_key          (issued_key)
	);

	kv_bucket_lookup u_kv_bucket_lookup (
		.ui_mig_clk        (ui_mig_clk),
		.ui_mig_rst        (ui_mig_rst),
		.read_issued       (read_issued),
		.issued_key        (issued_key),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.resp_valid        (resp_valid),
		.resp_hit          (resp_hit)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the kv store testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module kv_store_tb -f build.f \
	-o kv_store_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/kv_store_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

// ==== testbench/kv_mig_model.sv ====
`default_nettype none

`include "kv_cfg.svh"

module kv_mig_model
	import kv_pkg::*;
(
	input  wire           ui_mig_clk,
	input  wire           ui_mig_rst,
	output logic          init_calib_complete,
	input  wire           app_en,
	input  wire mig_req_t app_req,
	output logic          app_rdy,
	input  wire           app_wdf_wren,
	input  wire mig_wdf_t app_wdf,
	output logic          app_wdf_rdy,
	output logic          app_rd_data_valid,
	output line_t         app_rd_data
);

	localparam int BUCKETS = 1 << `KV_BUCKET_BITS;
	localparam int RD_LAT = 4;
	localparam int CALIB_CYCLES = 20;

	line_t lines [BUCKETS];
	line_t rd_line [RD_LAT];
	logic [RD_LAT-1:0] rd_vld;
	int calib_cnt;
	bucket_t b;

	assign b = bucket_t'(app_req.addr >> 6);

	initial begin
		void'($urandom(32'h187e68ee));
		init_calib_complete = 1'b0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
	end

	// --------------------
	// command acceptance
	// --------------------
	always @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			rd_vld <= '0;
			calib_cnt <= 0;
			// nonzero contents, so a missed sweep write shows up
			for (int i = 0; i < BUCKETS; i++) begin
				lines[i] <= {16{32'h5a00_0000 | 32'(i)}};
			end
		end else begin
			if (calib_cnt < CALIB_CYCLES) begin
				calib_cnt <= calib_cnt + 1;
			end
			rd_vld <= {rd_vld[RD_LAT-2:0], 1'b0};
			for (int i = 1; i < RD_LAT; i++) begin
				rd_line[i] <= rd_line[i-1];
			end
			if (app_en && app_rdy) begin
				if (app_req.cmd == mig_read) begin
					rd_vld[0] <= 1'b1;
					rd_line[0] <= lines[b];
				end else if (app_wdf_wren && app_wdf_rdy) begin
					// mask bit set keeps the old byte
					for (int i = 0; i < 64; i++) begin
						if (!app_wdf.mask[i]) begin
							lines[b][i*8 +: 8] <= app_wdf.data[i*8 +: 8];
						end
					end
				end
			end
		end
	end

	// outputs change just after the edge
	always @(posedge ui_mig_clk) begin
		#1;
		app_rdy = ($urandom % 4) != 0;
		app_wdf_rdy = ($urandom % 4) != 0;
		app_rd_data_valid = rd_vld[RD_LAT-1];
		app_rd_data = rd_line[RD_LAT-1];
		init_calib_complete = (calib_cnt >= CALIB_CYCLES);
	end

endmodule

`default_nettype wire

// ==== testbench/kv_store_checker.sv ====
`default_nettype none

module kv_store_checker
	import kv_pkg::*;
(
	input wire           ui_mig_clk,
	input wire           ui_mig_rst,
	input wire           init_calib_complete,
	input wire           app_en,
	input wire           app_rdy,
	input wire mig_req_t app_req,
	input wire           app_wdf_wren,
	input wire           resp_valid
);

	int pending;
	int fail_cnt = 0;

	// reads accepted by memory and not yet answered
	always @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			pending <= 0;
		end else begin
			pending <= pending + int'(app_en && app_rdy && app_req.cmd == mig_read)
				- int'(resp_valid);
		end
	end

	a_wren_is_write: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		app_wdf_wren |-> app_en && app_req.cmd == mig_write)
	else begin
		fail_cnt++;
		$error("write data offered without a write command");
	end

	a_no_early_cmd: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		!init_calib_complete |-> !app_en)
	else begin
		fail_cnt++;
		$error("memory command before calibration");
	end

	a_resp_has_key: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		resp_valid |-> pending > 0)
	else begin
		fail_cnt++;
		$error("response with no read in flight");
	end

endmodule

bind kv_store_top kv_store_checker u_kv_store_checker (
	.ui_mig_clk          (ui_mig_clk),
	.ui_mig_rst          (ui_mig_rst),
	.init_calib_complete (init_calib_complete),
	.app_en              (app_en),
	.app_rdy             (app_rdy),
	.app_req             (app_req),
	.app_wdf_wren        (app_wdf_wren),
	.resp_valid          (resp_valid)
);

`default_nettype wire

// ==== testbench/kv_store_tb.sv ====
`default_nettype none

`include "kv_cfg.svh"

module kv_store_tb
	import kv_pkg::*;
();

	localparam int BUCKETS = 1 << `KV_BUCKET_BITS;
	localparam int RANDOM_REQS = 200;
	localparam int DIRECTED_REQS = 23;
	localparam int TIMEOUT_CYCLES = (RANDOM_REQS + DIRECTED_REQS) * 40 + 2000;
	// bytes 0 to 15 written and everything above kept
	localparam strb_t SLOT0_MASK = {{48{1'b1}}, 16'h0000};

	logic ui_mig_clk;
	logic ui_mig_rst;
	logic init_calib_complete;
	logic req_valid;
	kv_req_t req;
	logic set_credit;
	logic init_mem;
	logic resp_valid;
	logic resp_hit;
	logic app_en;
	mig_req_t app_req;
	logic app_rdy;
	logic app_wdf_wren;
	mig_wdf_t app_wdf;
	logic app_wdf_rdy;
	logic app_rd_data_valid;
	line_t app_rd_data;

	// scoreboard state
	kv_key_t shadow [BUCKETS];
	kv_req_t set_q [$];
	logic exp_q [$];
	string name_q [$];
	bucket_t get_bucket_q [$];
	int sets_sent = 0;
	int gets_sent = 0;
	int set_credit_cnt = 0;
	int resp_cnt = 0;
	int fill_idx = 0;
	int errors = 0;

	tb_clock_gen u_tb_clock_gen (
		.ui_mig_clk (ui_mig_clk)
	);

	kv_mig_model u_kv_mig_model (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.init_calib_complete (init_calib_complete),
		.app_en              (app_en),
		.app_req             (app_req),
		.app_rdy             (app_rdy),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf             (app_wdf),
		.app_wdf_rdy         (app_wdf_rdy),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rd_data         (app_rd_data)
	);

	kv_store_top u_kv_store_top (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.init_calib_complete (init_calib_complete),
		.req_valid           (req_valid),
		.req                 (req),
		.set_credit          (set_credit),
		.init_mem            (init_mem),
		.resp_valid          (resp_valid),
		.resp_hit            (resp_hit),
		.app_en              (app_en),
		.app_req             (app_req),
		.app_rdy             (app_rdy),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf             (app_wdf),
		.app_wdf_rdy         (app_wdf_rdy),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rd_data         (app_rd_data)
	);

	// slots 1 to 3 still hold the zero key of the sweep
	function automatic logic expected_hit(input kv_key_t key, input kv_key_t stored);
		return (key == stored) || (key == '0);
	endfunction

	function automatic logic bucket_busy(input bucket_t b);
		foreach (get_bucket_q[i]) begin
			if (get_bucket_q[i] == b) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// credit rules plus ordering so a GET sees exactly the SETs sent before it
	function automatic logic may_send(input kv_op_e op, input bucket_t b);
		if (op == kv_set) begin
			return (sets_sent - set_credit_cnt < `KV_QUEUE_DEPTH) && !bucket_busy(b);
		end
		return (gets_sent - resp_cnt < `KV_QUEUE_DEPTH) && (set_credit_cnt == sets_sent);
	endfunction

	task automatic check_value(input string name, input line_t expected, input line_t actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic send_req(input string name, input kv_op_e op, input kv_hash_t hash,
		input kv_key_t key, input kv_value_t value);
		bucket_t b;
		b = bucket_t'(hash);
		@(posedge ui_mig_clk);
		#1;
		while (!may_send(op, b)) begin
			req_valid = 1'b0;
			@(posedge ui_mig_clk);
			#1;
		end
		req_valid = 1'b1;
		req = '{op: op, hash: hash, key: key, value: value};
		if (op == kv_set) begin
			shadow[b] = key;
			set_q.push_back(req);
			sets_sent++;
		end else begin
			exp_q.push_back(expected_hit(key, shadow[b]));
			name_q.push_back(name);
			get_bucket_q.push_back(b);
			gets_sent++;
		end
	endtask

	task automatic go_idle();
		@(posedge ui_mig_clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = u_kv_store_top.u_kv_store_checker.fail_cnt;
		$display("summary: %0d check errors, %0d assertion failures", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin : stimulus
		kv_op_e op;
		kv_hash_t hash;
		kv_key_t key;
		ui_mig_rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < BUCKETS; i++) begin
			shadow[i] = '0;
		end
		repeat (16) @(posedge ui_mig_clk);
		#1;
		ui_mig_rst = 1'b0;
		while (!init_mem) begin
			@(posedge ui_mig_clk);
			#1;
		end
		check_value("fill sweep count", line_t'(BUCKETS), line_t'(fill_idx));

		send_req("set then get", kv_set, 32'h0000_0103, 96'h1111_2222_3333, 32'hcafe_0001);
		send_req("set then get", kv_get, 32'h0000_0103, 96'h1111_2222_3333, '0);
		send_req("get unknown key", kv_get, 32'h0000_0005, 96'h4444, '0);
		// second SET in bucket 7 replaces the first
		send_req("replace", kv_set, 32'h0000_0007, 96'haaaa, 32'h1);
		send_req("replace", kv_set, 32'h0000_0017, 96'hbbbb, 32'h2);
		send_req("get replaced key", kv_get, 32'h0000_0007, 96'haaaa, '0);
		send_req("get newer key", kv_get, 32'h0000_0017, 96'hbbbb, '0);
		for (int i = 0; i < BUCKETS; i++) begin
			send_req("zero key", kv_get, kv_hash_t'(i), '0, '0);
		end

		// few buckets and keys so hits are common
		for (int n = 0; n < RANDOM_REQS; n++) begin
			op = ($urandom % 2 == 0) ? kv_set : kv_get;
			hash = $urandom & 32'hffff_ff03;
			key = kv_key_t'($urandom % 6);
			send_req("random", op, hash, key, $urandom);
		end
		go_idle();

		while ((resp_cnt != gets_sent) || (set_credit_cnt != sets_sent)) begin
			@(posedge ui_mig_clk);
			#1;
		end
		repeat (10) @(posedge ui_mig_clk);
		check_value("set credit count", line_t'(sets_sent), line_t'(set_credit_cnt));
		check_value("response count", line_t'(gets_sent), line_t'(resp_cnt));
		check_value("unmatched set writes", '0, line_t'(set_q.size()));
		finish_run();
	end

	// --------------------
	// compare
	// --------------------
	always @(posedge ui_mig_clk) begin : compare
		kv_req_t s;
		string name;
		logic exp_hit;
		if (!ui_mig_rst) begin
			if (app_en && app_rdy && app_wdf_wren && app_wdf_rdy) begin
				if (!init_calib_complete) begin
					$display("ERROR: memory write accepted before calibration");
					errors++;
				end
				if (!init_mem) begin
					check_value("fill address", line_t'(fill_idx * 64), line_t'(app_req.addr));
					check_value("fill data", '0, app_wdf.data);
					check_value("fill mask", '0, line_t'(app_wdf.mask));
					fill_idx++;
				end else if (set_q.size() == 0) begin
					$display("ERROR: memory write seen with no SET waiting");
					errors++;
				end else begin
					s = set_q.pop_front();
					check_value("set address", line_t'(int'(bucket_t'(s.hash)) * 64),
						line_t'(app_req.addr));
					check_value("set mask", line_t'(SLOT0_MASK), line_t'(app_wdf.mask));
					check_value("set data", line_t'({s.key, s.value}), app_wdf.data);
				end
			end
			if (set_credit) begin
				set_credit_cnt++;
				if (set_credit_cnt > sets_sent) begin
					$display("ERROR: more SET credits returned than SETs sent");
					errors++;
				end
			end
			if (resp_valid) begin
				resp_cnt++;
				if (exp_q.size() == 0) begin
					$display("ERROR: response arrived with no GET outstanding");
					errors++;
				end else begin
					name = name_q.pop_front();
					exp_hit = exp_q.pop_front();
					get_bucket_q.delete(0);
					check_value(name, line_t'(exp_hit), line_t'(resp_hit));
				end
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge ui_mig_clk);
		$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		errors++;
		finish_run();
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

// free running memory user clock
module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic ui_mig_clk
);

	initial begin
		ui_mig_clk = 1'b0;
	end

	always #(PERIOD / 2) ui_mig_clk = ~ui_mig_clk;

endmodule

`default_nettype wire
